// ==== fetch_pkg.sv ====
package fetch_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // opcodes
    ////////////////////////////////////////////////////////////////////////////

    // every other opcode is a plain instruction
    localparam logic [3:0] op_branch   = 4'hC;
    localparam logic [3:0] op_jump_imm = 4'hD;
    localparam logic [3:0] op_jump_reg = 4'hE;

    ////////////////////////////////////////////////////////////////////////////
    // instruction word, two views of the same 16 bits
    ////////////////////////////////////////////////////////////////////////////

    // conditional branch, pc relative
    typedef struct packed {
        logic [3:0] op;
        logic [3:0] cond;
        logic [7:0] offset;
    } br_fmt_t;

    // jump, absolute 12-bit target
    // register jump keeps the base reg number in target[3:0]
    typedef struct packed {
        logic [3:0]  op;
        logic [11:0] target;
    } jmp_fmt_t;

    typedef union packed {
        br_fmt_t  br_fmt;
        jmp_fmt_t jmp_fmt;
    } inst_word_u;

    ////////////////////////////////////////////////////////////////////////////
    // stage records
    ////////////////////////////////////////////////////////////////////////////

    // packet handed to decode, slot 0 in the low word
    typedef struct packed {
        logic [15:0] pc;
        logic [63:0] inst;
        logic [3:0]  slot_valid;
        logic [3:0]  pred_taken;
        logic [15:0] next_pc;
    } fetch_pkt_t;

    // outcome of the group scan
    typedef struct packed {
        logic        redirect;
        logic [1:0]  redirect_slot;
        logic        is_reg_jump;
        logic [15:0] target;
        logic [3:0]  slot_valid;
        logic [3:0]  pred_taken;
    } scan_result_t;

endpackage

// ==== inst_rom.sv ====
`timescale 1ns/1ps

module inst_rom #(
    parameter int ROM_DEPTH_BITS = 8
) (
    input  logic [15:0]                  pc,
    output fetch_pkg::inst_word_u [3:0]  inst
);

    // program image, word addressed
    logic [15:0] mem [0:(2**ROM_DEPTH_BITS)-1];

    initial begin
        $readmemh("program.hex", mem);
    end

    // four read ports at pc..pc+3
    // address is kept at ROM width so the group wraps at the end
    for (genvar k = 0; k < 4; k++) begin : g_port
        logic [ROM_DEPTH_BITS-1:0] addr;
        assign addr    = pc[ROM_DEPTH_BITS-1:0] + ROM_DEPTH_BITS'(k);
        assign inst[k] = mem[addr];
    end

endmodule

// ==== branch_predictor.sv ====
`timescale 1ns/1ps

module branch_predictor #(
    parameter int BP_INDEX_BITS = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [15:0] pc,
    input  logic        commit_valid,
    input  logic [15:0] commit_pc,
    input  logic        commit_taken,
    output logic [3:0]  pred
);

    localparam int NUM_CNT = 2**BP_INDEX_BITS;

    // 2-bit saturating counters, msb is the prediction
    logic [1:0] cnt [NUM_CNT];
    logic [BP_INDEX_BITS-1:0] cidx;

    assign cidx = commit_pc[BP_INDEX_BITS-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // lookup, one counter per slot
    ////////////////////////////////////////////////////////////////////////////

    for (genvar k = 0; k < 4; k++) begin : g_lookup
        logic [15:0] slot_pc;
        assign slot_pc = pc + 16'(k);
        // 2 or 3 means taken
        assign pred[k] = cnt[slot_pc[BP_INDEX_BITS-1:0]][1];
    end

    ////////////////////////////////////////////////////////////////////////////
    // update at commit
    ////////////////////////////////////////////////////////////////////////////

    // weakly not taken out of reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CNT; i++) begin
                cnt[i] <= 2'd1;
            end
        end else if (commit_valid) begin
            if (commit_taken && cnt[cidx] != 2'd3) begin
                cnt[cidx] <= cnt[cidx] + 2'd1;
            end else if (!commit_taken && cnt[cidx] != 2'd0) begin
                cnt[cidx] <= cnt[cidx] - 2'd1;
            end
        end
    end

    // counters saturate, never wrap past 0 or 3
    a_cnt_saturate: assert property (@(posedge clk) disable iff (!rst_n)
        commit_valid |=>
            ($past(commit_taken) && cnt[$past(cidx)] >= $past(cnt[cidx])) ||
            (!$past(commit_taken) && cnt[$past(cidx)] <= $past(cnt[cidx])));

endmodule

// ==== group_scan.sv ====
`timescale 1ns/1ps

module group_scan (
    input  logic                        [15:0] pc,
    input  fetch_pkg::inst_word_u       [3:0]  inst,
    input  logic                        [3:0]  pred,
    input  logic                        [15:0] jump_base,
    output fetch_pkg::scan_result_t            scan
);

    import fetch_pkg::*;

    logic [3:0]  is_br;
    logic [3:0]  is_ji;
    logic [3:0]  is_jr;
    // slot ends the group
    logic [3:0]  ends;
    logic [15:0] br_tgt [4];
    logic        blocked;
    logic [1:0]  slot;

    ////////////////////////////////////////////////////////////////////////////
    // per slot decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            is_br[k] = inst[k].br_fmt.op == op_branch;
            is_ji[k] = inst[k].jmp_fmt.op == op_jump_imm;
            is_jr[k] = inst[k].jmp_fmt.op == op_jump_reg;
            // taken branch or any jump
            ends[k]  = is_ji[k] | is_jr[k] | (is_br[k] & pred[k]);
            // pc + k + 1 + sext(offset)
            br_tgt[k] = pc + 16'(k) + 16'd1
                      + {{8{inst[k].br_fmt.offset[7]}}, inst[k].br_fmt.offset};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // first redirect and target
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        scan    = '0;
        blocked = 1'b0;
        // walk down so the lowest slot wins
        for (int k = 3; k >= 0; k--) begin
            if (ends[k]) begin
                scan.redirect      = 1'b1;
                scan.redirect_slot = 2'(k);
            end
        end
        // slots after the redirect drop out
        for (int k = 0; k < 4; k++) begin
            scan.slot_valid[k] = !blocked;
            scan.pred_taken[k] = !blocked && is_br[k] && pred[k];
            blocked            = blocked | ends[k];
        end
        slot             = scan.redirect_slot;
        scan.is_reg_jump = scan.redirect && is_jr[slot];
        if (is_jr[slot]) begin
            scan.target = jump_base;
        end else if (is_ji[slot]) begin
            scan.target = {4'h0, inst[slot].jmp_fmt.target};
        end else begin
            scan.target = br_tgt[slot];
        end
    end

endmodule

// ==== jump_resolver.sv ====
`timescale 1ns/1ps

module jump_resolver (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_pkg::scan_result_t scan,
    input  logic                    stall_fetch,
    input  logic                    has_mispredict,
    input  logic                    jump_base_rdy,
    output logic                    jump_wait,
    output logic                    jump_done,
    output logic                    jump_base_req
);

    logic jr_found;

    // unstalled group ending in a register jump
    assign jr_found = scan.redirect && scan.is_reg_jump && !stall_fetch;

    // base arrived, pc_gen takes it this cycle
    assign jump_done     = jump_wait && jump_base_rdy;
    assign jump_base_req = jump_wait;

    // single wait flag
    // a stall holds it even with the base ready, the level stays up
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            jump_wait <= 1'b0;
        end else if (has_mispredict) begin
            jump_wait <= 1'b0;
        end else if (jump_wait) begin
            if (jump_done && !stall_fetch) begin
                jump_wait <= 1'b0;
            end
        end else if (jr_found) begin
            jump_wait <= 1'b1;
        end
    end

endmodule

// ==== pc_gen.sv ====
`timescale 1ns/1ps

module pc_gen #(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  fetch_pkg::scan_result_t scan,
    input  logic                    jump_wait,
    input  logic                    jump_done,
    input  logic [15:0]             jump_base,
    input  logic                    stall_fetch,
    input  logic                    has_mispredict,
    input  logic [15:0]             pc_recovery,
    output logic [15:0]             pc,
    output logic [15:0]             next_pc
);

    ////////////////////////////////////////////////////////////////////////////
    // next pc priority
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (has_mispredict) begin
            next_pc = pc_recovery;
        end else if (stall_fetch) begin
            next_pc = pc;
        end else if (jump_done) begin
            next_pc = jump_base;
        end else if (jump_wait) begin
            // base not here yet
            next_pc = pc;
        end else if (scan.redirect && !scan.is_reg_jump) begin
            next_pc = scan.target;
        end else if (scan.redirect) begin
            // register jump just found, wait starts
            next_pc = pc;
        end else begin
            next_pc = pc + 16'd4;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else begin
            pc <= next_pc;
        end
    end

    // decode back-pressure freezes the pc, only recovery overrides it
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall_fetch && !has_mispredict |=> $stable(pc));

endmodule

// ==== fetch_out.sv ====
`timescale 1ns/1ps

module fetch_out (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                  [15:0] pc,
    input  fetch_pkg::inst_word_u [3:0]  inst,
    input  fetch_pkg::scan_result_t      scan,
    input  logic                  [15:0] next_pc,
    input  logic                         jump_wait,
    input  logic                         stall_fetch,
    input  logic                         has_mispredict,
    output logic                         pkt_valid,
    output fetch_pkg::fetch_pkt_t        pkt
);

    logic capture;

    // group leaves the pc stage this edge
    assign capture = !stall_fetch && !has_mispredict && !jump_wait;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_valid <= 1'b0;
        end else if (has_mispredict) begin
            pkt_valid <= 1'b0;
        end else if (!stall_fetch) begin
            pkt_valid <= !jump_wait;
        end
    end

    // packet payload
    always_ff @(posedge clk) begin
        if (capture) begin
            pkt.pc         <= pc;
            pkt.inst       <= inst;
            pkt.slot_valid <= scan.slot_valid;
            pkt.pred_taken <= scan.pred_taken;
            // register jump target is unknown here
            pkt.next_pc    <= (scan.redirect && scan.is_reg_jump) ? 16'h0000 : next_pc;
        end
    end

    // group rule from the scan, seen at the decode boundary
    a_slots_contig: assert property (@(posedge clk) disable iff (!rst_n)
        pkt_valid |-> pkt.slot_valid inside {4'b0001, 4'b0011, 4'b0111, 4'b1111});

endmodule

// ==== fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top #(
    parameter logic [15:0] RESET_PC       = 16'h0000,
    parameter int          BP_INDEX_BITS  = 4,
    parameter int          ROM_DEPTH_BITS = 8
) (
    input  logic                  clk,
    input  logic                  rst_n,
    // decode
    input  logic                  stall_fetch,
    // rob
    input  logic                  has_mispredict,
    input  logic [15:0]           pc_recovery,
    input  logic                  commit_valid,
    input  logic [15:0]           commit_pc,
    input  logic                  commit_taken,
    // register file
    input  logic                  jump_base_rdy,
    input  logic [15:0]           jump_base,
    output logic                  pkt_valid,
    output fetch_pkg::fetch_pkt_t pkt,
    output logic                  jump_base_req
);

    import fetch_pkg::*;

    logic [15:0]      pc;
    logic [15:0]      next_pc;
    inst_word_u [3:0] inst;
    logic [3:0]       pred;
    scan_result_t     scan;
    logic             jump_wait;
    logic             jump_done;

    ////////////////////////////////////////////////////////////////////////////
    // pc stage
    ////////////////////////////////////////////////////////////////////////////

    inst_rom #(.ROM_DEPTH_BITS(ROM_DEPTH_BITS)) u_rom (
        .pc   (pc),
        .inst (inst)
    );

    branch_predictor #(.BP_INDEX_BITS(BP_INDEX_BITS)) u_bp (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc           (pc),
        .commit_valid (commit_valid),
        .commit_pc    (commit_pc),
        .commit_taken (commit_taken),
        .pred         (pred)
    );

    group_scan u_scan (
        .pc        (pc),
        .inst      (inst),
        .pred      (pred),
        .jump_base (jump_base),
        .scan      (scan)
    );

    jump_resolver u_jr (
        .clk            (clk),
        .rst_n          (rst_n),
        .scan           (scan),
        .stall_fetch    (stall_fetch),
        .has_mispredict (has_mispredict),
        .jump_base_rdy  (jump_base_rdy),
        .jump_wait      (jump_wait),
        .jump_done      (jump_done),
        .jump_base_req  (jump_base_req)
    );

    pc_gen #(.RESET_PC(RESET_PC)) u_pc (
        .clk            (clk),
        .rst_n          (rst_n),
        .scan           (scan),
        .jump_wait      (jump_wait),
        .jump_done      (jump_done),
        .jump_base      (jump_base),
        .stall_fetch    (stall_fetch),
        .has_mispredict (has_mispredict),
        .pc_recovery    (pc_recovery),
        .pc             (pc),
        .next_pc        (next_pc)
    );

    ////////////////////////////////////////////////////////////////////////////
    // output register to decode
    ////////////////////////////////////////////////////////////////////////////

    fetch_out u_out (
        .clk            (clk),
        .rst_n          (rst_n),
        .pc             (pc),
        .inst           (inst),
        .scan           (scan),
        .next_pc        (next_pc),
        .jump_wait      (jump_wait),
        .stall_fetch    (stall_fetch),
        .has_mispredict (has_mispredict),
        .pkt_valid      (pkt_valid),
        .pkt            (pkt)
    );

endmodule

// ==== fetch_checker.sv ====
`timescale 1ns/1ps

module fetch_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  stall_fetch,
    input  logic                  has_mispredict,
    input  logic [15:0]           pc_recovery,
    input  logic                  commit_valid,
    input  logic [15:0]           commit_pc,
    input  logic                  commit_taken,
    input  logic                  jump_base_rdy,
    input  logic [15:0]           jump_base,
    input  logic                  pkt_valid,
    input  fetch_pkg::fetch_pkt_t pkt,
    input  logic                  jump_base_req,
    input  int                    test_id,
    input  logic                  test_done,
    output int                    errors
);

    import fetch_pkg::*;

    logic [15:0] rom [0:255];
    // mirrored counters, and their value before the last edge
    logic [1:0]  cnt [16];
    logic [1:0]  snap [16];
    logic [15:0] exp_pc;
    // register jump wait the fetch stage should be in
    logic        jr_pend;
    logic        jr_grp;
    // what the pc stage did at the last edge
    logic        capt_last;
    logic        hold_last;
    logic        wait_last;
    logic        mp_last;
    logic        valid_last;
    fetch_pkt_t  pkt_last;
    int          pkts;
    int          test_pkts;
    int          test_errs;
    fetch_pkt_t  want;

    initial begin
        $readmemh("program.hex", rom);
        errors = 0;
        pkts = 0;
        test_pkts = 0;
        test_errs = 0;
    end

    ////////////////////////////////////////////////////////////////////////////
    // expected packet for a group start pc
    ////////////////////////////////////////////////////////////////////////////

    function automatic fetch_pkt_t expect_pkt(input logic [15:0] gpc, output logic reg_jump);
        fetch_pkt_t  p;
        logic [15:0] a;
        logic [15:0] w;
        logic        stop;
        p         = '0;
        p.pc      = gpc;
        p.next_pc = gpc + 16'd4;
        stop      = 1'b0;
        reg_jump  = 1'b0;
        for (int k = 0; k < 4; k++) begin
            a = gpc + 16'(k);
            w = rom[a[7:0]];
            p.inst[k*16 +: 16] = w;
            if (!stop) begin
                p.slot_valid[k] = 1'b1;
                if (w[15:12] == 4'hC && snap[a[3:0]] >= 2'd2) begin
                    // taken branch, relative to the following word
                    p.pred_taken[k] = 1'b1;
                    p.next_pc = a + 16'd1 + {{8{w[7]}}, w[7:0]};
                    stop = 1'b1;
                end else if (w[15:12] == 4'hD) begin
                    p.next_pc = {4'h0, w[11:0]};
                    stop = 1'b1;
                end else if (w[15:12] == 4'hE) begin
                    // base unknown at fetch
                    p.next_pc = 16'h0000;
                    reg_jump = 1'b1;
                    stop = 1'b1;
                end
            end
        end
        return p;
    endfunction

    task automatic report(input string msg);
        $display("%s", msg);
        errors++;
        test_errs++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // compare, pre-edge values at each rising edge
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 16; i++) begin
                cnt[i] = 2'd1;
                snap[i] = 2'd1;
            end
            exp_pc = 16'h0000;
            jr_pend = 1'b0;
            capt_last = 1'b0;
            hold_last = 1'b0;
            wait_last = 1'b0;
            mp_last = 1'b0;
            valid_last = 1'b0;
        end else begin
            if (mp_last) begin
                if (pkt_valid) begin
                    report("packet valid in the cycle after a misprediction");
                end
            end else if (hold_last) begin
                // decode stalled, output register frozen
                if (pkt_valid !== valid_last) begin
                    report($sformatf("MISMATCH pkt_valid exp %h got %h",
                        valid_last, pkt_valid));
                end else if (pkt_valid && pkt !== pkt_last) begin
                    report($sformatf("MISMATCH pkt exp %h got %h", pkt_last, pkt));
                end
            end else if (wait_last) begin
                if (pkt_valid) begin
                    report("packet captured while a register jump wait was pending");
                end
            end else if (capt_last) begin
                if (!pkt_valid) begin
                    report($sformatf("no packet for the group at pc %h", exp_pc));
                end else begin
                    pkts++;
                    test_pkts++;
                    want = expect_pkt(exp_pc, jr_grp);
                    if (pkt.pc !== exp_pc) begin
                        report($sformatf("packet pc %h does not follow the expected pc %h",
                            pkt.pc, exp_pc));
                    end
                    if (pkt.inst !== want.inst) begin
                        report($sformatf("MISMATCH pkt.inst exp %h got %h",
                            want.inst, pkt.inst));
                    end
                    if (pkt.slot_valid !== want.slot_valid) begin
                        report($sformatf("MISMATCH pkt.slot_valid exp %h got %h",
                            want.slot_valid, pkt.slot_valid));
                    end
                    if (pkt.pred_taken !== want.pred_taken) begin
                        report($sformatf("MISMATCH pkt.pred_taken exp %h got %h",
                            want.pred_taken, pkt.pred_taken));
                    end
                    if (pkt.next_pc !== want.next_pc) begin
                        report($sformatf("MISMATCH pkt.next_pc exp %h got %h",
                            want.next_pc, pkt.next_pc));
                    end
                    exp_pc = want.next_pc;
                    // wait began at the edge that captured this group
                    jr_pend = jr_grp;
                end
            end
            if (jump_base_req !== jr_pend) begin
                report($sformatf("MISMATCH jump_base_req exp %h got %h",
                    jr_pend, jump_base_req));
            end
            // pc stage decision at this edge
            hold_last = stall_fetch && !has_mispredict;
            wait_last = !stall_fetch && !has_mispredict && jr_pend;
            capt_last = !stall_fetch && !has_mispredict && !jr_pend;
            mp_last = has_mispredict;
            valid_last = pkt_valid;
            pkt_last = pkt;
            // redirects taken at this edge
            if (has_mispredict) begin
                exp_pc = pc_recovery;
                jr_pend = 1'b0;
            end else if (jr_pend && jump_base_rdy && !stall_fetch) begin
                exp_pc = jump_base;
                jr_pend = 1'b0;
            end
            snap = cnt;
            if (commit_valid) begin
                if (commit_taken && cnt[commit_pc[3:0]] != 2'd3) begin
                    cnt[commit_pc[3:0]] = cnt[commit_pc[3:0]] + 2'd1;
                end else if (!commit_taken && cnt[commit_pc[3:0]] != 2'd0) begin
                    cnt[commit_pc[3:0]] = cnt[commit_pc[3:0]] - 2'd1;
                end
            end
        end
        if (test_done) begin
            $display("test %0d done: %0d packets, %0d errors", test_id, test_pkts, test_errs);
            test_pkts = 0;
            test_errs = 0;
            if (test_id == 6) begin
                $display("summary: 6 tests, %0d packets, %0d errors", pkts, errors);
            end
        end
    end

endmodule

// ==== tb_fetch.sv ====
`timescale 1ns/1ps

module tb_fetch;

    import fetch_pkg::*;

    // six tests of at most 40 cycles, plus margin
    localparam int TIMEOUT_CYCLES = 6 * 40 + 160;

    logic        clk;
    logic        rst_n;
    logic        stall_fetch;
    logic        has_mispredict;
    logic [15:0] pc_recovery;
    logic        commit_valid;
    logic [15:0] commit_pc;
    logic        commit_taken;
    logic        jump_base_rdy;
    logic [15:0] jump_base;
    logic        pkt_valid;
    fetch_pkt_t  pkt;
    logic        jump_base_req;
    int          test_id;
    logic        test_done;
    int          errors;
    int          cycles;
    logic [31:0] rng;

    fetch_top UUT (
        .clk(clk), .rst_n(rst_n), .stall_fetch(stall_fetch),
        .has_mispredict(has_mispredict), .pc_recovery(pc_recovery),
        .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_taken(commit_taken),
        .jump_base_rdy(jump_base_rdy), .jump_base(jump_base),
        .pkt_valid(pkt_valid), .pkt(pkt), .jump_base_req(jump_base_req)
    );

    fetch_checker u_chk (
        .clk(clk), .rst_n(rst_n), .stall_fetch(stall_fetch),
        .has_mispredict(has_mispredict), .pc_recovery(pc_recovery),
        .commit_valid(commit_valid), .commit_pc(commit_pc), .commit_taken(commit_taken),
        .jump_base_rdy(jump_base_rdy), .jump_base(jump_base),
        .pkt_valid(pkt_valid), .pkt(pkt), .jump_base_req(jump_base_req),
        .test_id(test_id), .test_done(test_done), .errors(errors)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout after %0d cycles in test %0d", cycles, test_id);
            $display("Errors found");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // inputs change 1 ns after the edge
    task automatic tick();
        @(posedge clk);
        #1;
    endtask

    task automatic wait_req();
        while (!jump_base_req) begin
            tick();
        end
    endtask

    // base arrives after a random delay
    task automatic resolve(input logic [15:0] base);
        rng = xorshift(rng);
        repeat (1 + rng[1:0]) tick();
        jump_base = base;
        jump_base_rdy = 1'b1;
        tick();
        jump_base_rdy = 1'b0;
    endtask

    task automatic commit(input logic [15:0] cpc, input logic taken);
        commit_valid = 1'b1;
        commit_pc = cpc;
        commit_taken = taken;
        tick();
        commit_valid = 1'b0;
    endtask

    task automatic mispredict(input logic [15:0] target);
        has_mispredict = 1'b1;
        pc_recovery = target;
        tick();
        has_mispredict = 1'b0;
    endtask

    task automatic end_test();
        test_done = 1'b1;
        tick();
        test_done = 1'b0;
    endtask

    initial begin
        rst_n = 1'b0;
        stall_fetch = 1'b0;
        has_mispredict = 1'b0;
        pc_recovery = 16'h0000;
        commit_valid = 1'b0;
        commit_pc = 16'h0000;
        commit_taken = 1'b0;
        jump_base_rdy = 1'b0;
        jump_base = 16'h0000;
        test_id = 0;
        test_done = 1'b0;
        cycles = 0;
        rng = 32'd73819;
        repeat (4) tick();
        rst_n = 1'b1;

        // straight code up to the first register jump
        test_id = 1;
        wait_req();
        end_test();

        // train the backward branch at 7, then untrain it
        test_id = 2;
        commit(16'h0007, 1'b1);
        commit(16'h0007, 1'b1);
        // resume mid group so the branch sits in slot 2
        resolve(16'h0005);
        repeat (12) tick();
        commit(16'h0007, 1'b0);
        commit(16'h0007, 1'b0);
        end_test();

        // jump from 9 to c, wait begins at d
        test_id = 3;
        wait_req();
        end_test();

        test_id = 4;
        resolve(16'h0008);
        wait_req();
        end_test();

        // random back-pressure with the base offered at random
        test_id = 5;
        resolve(16'h0000);
        for (int i = 0; i < 30; i++) begin
            rng = xorshift(rng);
            stall_fetch = rng[0];
            jump_base_rdy = jump_base_req & rng[1];
            tick();
        end
        stall_fetch = 1'b0;
        jump_base_rdy = 1'b0;
        end_test();

        // recovery in flight and during a jump wait
        test_id = 6;
        mispredict(16'h0004);
        wait_req();
        mispredict(16'h0008);
        wait_req();
        resolve(16'h0000);
        repeat (4) tick();
        end_test();

        repeat (2) tick();
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// ==== program.hex ====
// one 16-bit instruction word per line, word address 0 upward
// op C branch (8-bit offset), D jump imm (12-bit target), E jump reg, others plain
1000
1001
1002
1003
1004
1005
1006
C0F8
1008
D00C
100A
100B
100C
E003
100E
D000

// ==== filelist.f ====
fetch_pkg.sv
inst_rom.sv
branch_predictor.sv
group_scan.sv
jump_resolver.sv
pc_gen.sv
fetch_out.sv
fetch_top.sv
fetch_checker.sv
tb_fetch.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_fetch \
    -f filelist.f -o sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0
